// ==== rtl/hyper_consts.svh ====
//####################################################################
// Widths and depths shared by the block mover. Four LSAB sections follow
// from HYPER_SECT_W; a bank only decodes DRAM_DEPTH_LOG address bits
//####################################################################
`ifndef HYPER_CONSTS_SVH
`define HYPER_CONSTS_SVH

// Word address of a 16-bit LSAB word
`define HYPER_ADDR_W 12
// Requested and sent word counts
`define HYPER_COUNT_W 6
`define HYPER_SECT_W 2

`define HYPER_WORD_W 16
`define HYPER_DWORD_W 32
// One enable per byte lane of a DRAM word
`define HYPER_WE_W 4

`define LSAB_DEPTH_LOG 4
`define DRAM_DEPTH_LOG 6

`endif

// ==== rtl/hyper_types_pkg.sv ====
//####################################################################
// Data and address types of the mover datapath
// Bank select is one-hot, all zero means no bank
//####################################################################
`include "hyper_consts.svh"

package hyper_types_pkg;

	// Address of one 16-bit word
	typedef logic [`HYPER_ADDR_W-1:0] word_addr_t;
	// Address of one 32-bit DRAM word, the word address without bit 0
	typedef logic [`HYPER_ADDR_W-2:0] dram_addr_t;

	typedef logic [`HYPER_COUNT_W-1:0] count_t;
	typedef logic [`HYPER_SECT_W-1:0] section_t;

	// One-hot bank request
	typedef logic [1:0] bank_sel_t;

	typedef logic [`HYPER_WORD_W-1:0] lsab_word_t;
	typedef logic [`HYPER_DWORD_W-1:0] dram_word_t;
	typedef logic [`HYPER_WE_W-1:0] byte_en_t;

endpackage

// ==== rtl/hyper_state_pkg.sv ====
//####################################################################
// State encoding of the block mover FSM
//####################################################################

package hyper_state_pkg;

	// Idle waits for issue, move pops one word per cycle,
	// done holds for a single cycle while the status is visible
	typedef enum logic [1:0]
	{
		MV_IDLE,
		MV_MOVE,
		MV_DONE
	} mover_state_t;

endpackage

// ==== rtl/lsab_if.sv ====
//####################################################################
// LSAB read bus and MCU write bus of the mover
// The read bus carries one stop and one int flag per section
//####################################################################
`include "hyper_consts.svh"

interface lsab_rd_if
	import hyper_types_pkg::*;
();

	logic read;
	section_t section;
	lsab_word_t data;
	// Per section empty and full flags
	logic [(1 << `HYPER_SECT_W)-1:0] stop;
	logic [(1 << `HYPER_SECT_W)-1:0] int_flag;

	modport ctrl (output read, output section, input stop, input int_flag);
	modport buffer (input read, input section, output data, output stop, output int_flag);
	// The collector only looks at the popped word
	modport sink (input data);

endinterface

interface mcu_wr_if
	import hyper_types_pkg::*;
();

	dram_addr_t coll_address;
	byte_en_t we_array;
	bank_sel_t request_access;
	dram_word_t data;

	modport collector (output coll_address, output we_array, output request_access, output data);
	modport bank (input coll_address, input we_array, input request_access, input data);

endinterface

// ==== rtl/lsab_sections.sv ====
//####################################################################
// Four FIFO sections of 2^LSAB_DEPTH_LOG words each
// A host write to a full section is dropped; a pop of an empty one is ignored
// Popped data appears one cycle after the read strobe
//####################################################################
`include "hyper_consts.svh"

module lsab_sections
	import hyper_types_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic fill_write,
	input section_t fill_section,
	input lsab_word_t fill_data,
	lsab_rd_if.buffer rd
);

	localparam int N_SECT = 1 << `HYPER_SECT_W;
	localparam int DEPTH = 1 << `LSAB_DEPTH_LOG;

	logic [N_SECT-1:0] empty;
	logic [N_SECT-1:0] full;
	logic [N_SECT-1:0] push_sel;
	logic [N_SECT-1:0] pop_sel;
	// Word at the read pointer of every section
	logic [N_SECT-1:0][`HYPER_WORD_W-1:0] head;

	// Only one section is written and one is popped per cycle
	always_comb
	begin
		push_sel = '0;
		pop_sel = '0;
		push_sel[fill_section] = fill_write && !full[fill_section];
		pop_sel[rd.section] = rd.read && !empty[rd.section];
	end

	//####################################################################
	// Section storage
	//####################################################################
	for (genvar g = 0; g < N_SECT; g++)
	begin : g_sect
		lsab_word_t mem [DEPTH];
		logic [`LSAB_DEPTH_LOG-1:0] wr_ptr;
		logic [`LSAB_DEPTH_LOG-1:0] rd_ptr;
		// One bit wider than the pointers so a full section is distinct from empty
		logic [`LSAB_DEPTH_LOG:0] fill_cnt;

		assign empty[g] = (fill_cnt == '0);
		assign full[g] = fill_cnt[`LSAB_DEPTH_LOG];
		assign head[g] = mem[rd_ptr];

		always_ff @(posedge CLK)
		begin
			if (!RST)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				fill_cnt <= '0;
			end
			else
			begin
				if (push_sel[g])
				begin
					wr_ptr <= wr_ptr + 1'b1;
				end
				if (pop_sel[g])
				begin
					rd_ptr <= rd_ptr + 1'b1;
				end
				case ({push_sel[g], pop_sel[g]})
					2'b10: fill_cnt <= fill_cnt + 1'b1;
					2'b01: fill_cnt <= fill_cnt - 1'b1;
					default: fill_cnt <= fill_cnt;
				endcase
			end
		end

		always_ff @(posedge CLK)
		begin
			if (push_sel[g])
			begin
				mem[wr_ptr] <= fill_data;
			end
		end
	end

	assign rd.stop = empty;
	assign rd.int_flag = full;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd.data <= '0;
		end
		else if (|pop_sel)
		begin
			rd.data <= head[rd.section];
		end
	end

endmodule

// ==== rtl/mvblck_ctrl.sv ====
//####################################################################
// Block mover control. Pops one word per cycle until the count is used up
// or the section runs empty; an empty section at the start is an abrupt stop
// Issue is only accepted while idle
//####################################################################
`include "hyper_consts.svh"

module mvblck_ctrl
	import hyper_types_pkg::*;
	import hyper_state_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic issue,
	input word_addr_t start_address,
	input count_t count_req,
	input section_t section,
	input bank_sel_t dram_sel,
	lsab_rd_if.ctrl rd,
	output logic take,
	output word_addr_t take_addr,
	output logic take_last,
	output bank_sel_t bank,
	output count_t count_sent,
	output logic working,
	output logic irq_out,
	output logic abrupt_stop,
	output logic done
);

	mover_state_t state;
	count_t len_left;
	count_t req_q;
	word_addr_t track_addr;
	section_t sect_q;
	logic stop_sel;
	logic int_sel;
	logic go;

	// Flags of the section that this move drains
	assign stop_sel = rd.stop[sect_q];
	assign int_sel = rd.int_flag[sect_q];

	// A pop happens in every move cycle that still has words and data
	assign go = (state == MV_MOVE) && (len_left != '0) && !stop_sel;

	assign rd.read = go;
	assign rd.section = sect_q;

	assign take = go;
	assign take_addr = track_addr;
	// The finishing cycle lines up with the data of the final pop
	assign take_last = (state == MV_MOVE) && !go;

	//####################################################################
	// Mover FSM
	//####################################################################
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= MV_IDLE;
			len_left <= '0;
			req_q <= '0;
			track_addr <= '0;
			sect_q <= '0;
			bank <= '0;
			count_sent <= '0;
			working <= 1'b0;
			irq_out <= 1'b0;
			abrupt_stop <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			// Busy seen one cycle late, as the host side expects
			working <= (state != MV_IDLE);
			done <= 1'b0;
			case (state)
				MV_IDLE:
				begin
					if (issue)
					begin
						sect_q <= section;
						len_left <= count_req;
						req_q <= count_req;
						track_addr <= start_address;
						bank <= dram_sel;
						state <= MV_MOVE;
					end
				end
				MV_MOVE:
				begin
					if (go)
					begin
						track_addr <= track_addr + `HYPER_ADDR_W'(1);
						len_left <= len_left - `HYPER_COUNT_W'(1);
					end
					else
					begin
						count_sent <= req_q - len_left;
						irq_out <= int_sel;
						// Words still owed means the section ran dry
						abrupt_stop <= (len_left != '0);
						done <= 1'b1;
						state <= MV_DONE;
					end
				end
				MV_DONE: state <= MV_IDLE;
				default: state <= MV_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/mcu_collector.sv ====
//####################################################################
// Pairs popped LSAB words into DRAM writes. Even words go to lanes 1:0,
// odd words to lanes 3:2. Pops of one move are assumed to be consecutive
//####################################################################
`include "hyper_consts.svh"

module mcu_collector
	import hyper_types_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic take,
	input word_addr_t take_addr,
	input logic take_last,
	input bank_sel_t bank,
	lsab_rd_if.sink rd,
	mcu_wr_if.collector wr
);

	// Pop information delayed to the cycle that carries the data
	logic take_d;
	word_addr_t addr_d;
	bank_sel_t bank_d;
	// Even half waiting for its odd partner
	logic pend_valid;
	lsab_word_t pend_data;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			take_d <= 1'b0;
			addr_d <= '0;
			bank_d <= '0;
			pend_valid <= 1'b0;
			pend_data <= '0;
			wr.coll_address <= '0;
			wr.we_array <= '0;
			wr.request_access <= '0;
			wr.data <= '0;
		end
		else
		begin
			take_d <= take;
			addr_d <= take_addr;
			bank_d <= bank;
			wr.request_access <= '0;
			if (take_d)
			begin
				if (addr_d[0])
				begin
					// Odd word closes the DRAM word, alone or with its pair
					wr.coll_address <= addr_d[`HYPER_ADDR_W-1:1];
					wr.we_array <= pend_valid ? 4'b1111 : 4'b1100;
					wr.data <= {rd.data, pend_data};
					wr.request_access <= bank_d;
					pend_valid <= 1'b0;
				end
				else if (take_last)
				begin
					// Final word on an even address goes out alone
					wr.coll_address <= addr_d[`HYPER_ADDR_W-1:1];
					wr.we_array <= 4'b0011;
					wr.data <= {lsab_word_t'(0), rd.data};
					wr.request_access <= bank_d;
					pend_valid <= 1'b0;
				end
				else
				begin
					pend_valid <= 1'b1;
					pend_data <= rd.data;
				end
			end
		end
	end

endmodule

// ==== rtl/dram_banks.sv ====
//####################################################################
// Two small DRAM banks with byte lane writes. Only the low
// DRAM_DEPTH_LOG address bits are decoded, higher bits alias
//####################################################################
`include "hyper_consts.svh"

module dram_banks
	import hyper_types_pkg::*;
(
	input logic CLK,
	input logic RST,
	mcu_wr_if.bank wr,
	input logic rd_bank,
	input dram_addr_t rd_addr,
	output dram_word_t rd_data
);

	localparam int DEPTH = 1 << `DRAM_DEPTH_LOG;
	localparam int N_BANK = $bits(bank_sel_t);
	localparam int BYTE_W = `HYPER_DWORD_W / `HYPER_WE_W;

	dram_word_t mem [N_BANK][DEPTH];
	logic [`DRAM_DEPTH_LOG-1:0] wr_idx;
	logic [`DRAM_DEPTH_LOG-1:0] rd_idx;

	assign wr_idx = wr.coll_address[`DRAM_DEPTH_LOG-1:0];
	assign rd_idx = rd_addr[`DRAM_DEPTH_LOG-1:0];

	// Each request bit selects its own bank, lanes not enabled keep their data
	always_ff @(posedge CLK)
	begin
		for (int k = 0; k < N_BANK; k++)
		begin
			for (int b = 0; b < `HYPER_WE_W; b++)
			begin
				if (wr.request_access[k] && wr.we_array[b])
				begin
					mem[k][wr_idx][b*BYTE_W +: BYTE_W] <= wr.data[b*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// Readback port for checking
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_data <= '0;
		end
		else
		begin
			rd_data <= mem[rd_bank][rd_idx];
		end
	end

endmodule

// ==== rtl/hyper_mover_top.sv ====
//####################################################################
// Block mover from the LSAB sections into two DRAM banks
// One move at a time; issue is ignored until done has pulsed
//####################################################################

module hyper_mover_top
	import hyper_types_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic fill_write,
	input section_t fill_section,
	input lsab_word_t fill_data,
	input logic issue,
	input word_addr_t start_address,
	input count_t count_req,
	input section_t section,
	input bank_sel_t dram_sel,
	output count_t count_sent,
	output logic working,
	output logic irq_out,
	output logic abrupt_stop,
	output logic done,
	output logic lsab_read,
	output bank_sel_t request_access,
	input logic rd_bank,
	input dram_addr_t rd_addr,
	output dram_word_t rd_data
);

	lsab_rd_if rd_bus ();
	mcu_wr_if wr_bus ();

	logic take;
	word_addr_t take_addr;
	logic take_last;
	bank_sel_t bank;

	assign lsab_read = rd_bus.read;
	assign request_access = wr_bus.request_access;

	lsab_sections lsab_sections_inst (
		.CLK(CLK), .RST(RST), .fill_write(fill_write), .fill_section(fill_section),
		.fill_data(fill_data), .rd(rd_bus.buffer)
	);

	mvblck_ctrl mvblck_ctrl_inst (
		.CLK(CLK), .RST(RST), .issue(issue), .start_address(start_address),
		.count_req(count_req), .section(section), .dram_sel(dram_sel), .rd(rd_bus.ctrl),
		.take(take), .take_addr(take_addr), .take_last(take_last), .bank(bank),
		.count_sent(count_sent), .working(working), .irq_out(irq_out),
		.abrupt_stop(abrupt_stop), .done(done)
	);

	mcu_collector mcu_collector_inst (
		.CLK(CLK), .RST(RST), .take(take), .take_addr(take_addr), .take_last(take_last),
		.bank(bank), .rd(rd_bus.sink), .wr(wr_bus.collector)
	);

	dram_banks dram_banks_inst (
		.CLK(CLK), .RST(RST), .wr(wr_bus.bank), .rd_bank(rd_bank), .rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

// ==== tests/mover_properties.sv ====
//####################################################################
// Checks on the mover control, bound into mvblck_ctrl
// fail_count counts failed checks so the testbench can end the run
//####################################################################

module mover_properties
	import hyper_types_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic read,
	input logic sect_empty,
	input logic working,
	input logic done,
	input bank_sel_t bank
);

	int fail_count = 0;

	// No pop is sent to a section that holds no words
	a_no_empty_pop: assert property (@(posedge CLK) disable iff (!RST) !(read && sect_empty))
		else
		begin
			$error("pop strobe while the selected section is empty");
			fail_count++;
		end

	// The held select feeds request_access, so it must be zero or one-hot
	a_bank_onehot: assert property (@(posedge CLK) disable iff (!RST) $onehot0(bank))
		else
		begin
			$error("bank select is not one-hot");
			fail_count++;
		end

	a_reset_quiet: assert property (@(posedge CLK) $rose(RST) |-> (!working && !done))
		else
		begin
			$error("working or done high right after reset");
			fail_count++;
		end

	a_done_pulse: assert property (@(posedge CLK) disable iff (!RST) done |=> !done)
		else
		begin
			$error("done lasted more than one cycle");
			fail_count++;
		end

endmodule

// ==== tests/mover_tb.sv ====
//####################################################################
// Testbench of the block mover. Moves run one at a time and each is
// checked against a model of the sections and the two DRAM banks
//####################################################################

module mover_tb
	import hyper_types_pkg::*;
();

	// Words actually sent by all moves, sets the watchdog limit
	localparam int TOTAL_WORDS = 10 + 5 + 8 + 5 + 0 + 3 + 0;
	localparam int LIMIT_CYCLES = 20 * TOTAL_WORDS + 200;

	logic CLK;
	logic RST;
	logic fill_write;
	section_t fill_section;
	lsab_word_t fill_data;
	logic issue;
	word_addr_t start_address;
	count_t count_req;
	section_t section;
	bank_sel_t dram_sel;
	count_t count_sent;
	logic working;
	logic irq_out;
	logic abrupt_stop;
	logic done;
	logic lsab_read;
	bank_sel_t request_access;
	logic rd_bank;
	dram_addr_t rd_addr;
	dram_word_t rd_data;

	integer seed;
	int pop_total = 0;
	int write_total = 0;
	// Model of the section contents and of the bank lanes written so far
	logic [15:0] model_q [4][$];
	logic [31:0] ref_mem [2][64];
	logic [3:0] ref_en [2][64];

	hyper_mover_top hyper_mover_top_inst (.*);

	bind mvblck_ctrl mover_properties mover_properties_inst (
		.CLK(CLK), .RST(RST), .read(go), .sect_empty(stop_sel), .working(working),
		.done(done), .bank(bank)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(negedge CLK)
	begin
		if (lsab_read)
		begin
			pop_total++;
		end
		if (request_access != '0)
		begin
			write_total++;
		end
	end

	always @(negedge CLK)
	begin
		if (hyper_mover_top_inst.mvblck_ctrl_inst.mover_properties_inst.fail_count != 0)
		begin
			$display("A property of the mover control failed");
			$display("Simulation FAILED");
			$fatal(1, "property failure");
		end
	end

	initial
	begin
		repeat (LIMIT_CYCLES) @(posedge CLK);
		$display("Timeout, the moves did not finish in %0d cycles", LIMIT_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("error at time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic fill(input int sect, input int n);
		int i;
		int rnd;
		for (i = 0; i < n; i++)
		begin
			@(negedge CLK);
			rnd = $random(seed);
			fill_write = 1'b1;
			fill_section = section_t'(sect);
			fill_data = rnd[15:0];
			// A write to a full section is dropped by the LSAB
			if (model_q[sect].size() < 16)
			begin
				model_q[sect].push_back(rnd[15:0]);
			end
		end
		@(negedge CLK);
		fill_write = 1'b0;
	endtask

	// Issues one move, waits for done, then checks status, pops, writes and bank data
	task automatic do_move(input int sect, input int start, input int cnt, input int bank);
		int n_sent;
		int pop_base;
		int write_base;
		int i;
		int addr;
		int idx;
		logic [31:0] mask;
		int touched [$];
		n_sent = (cnt < model_q[sect].size()) ? cnt : model_q[sect].size();
		for (i = 0; i < n_sent; i++)
		begin
			addr = start + i;
			idx = (addr >> 1) % 64;
			if (addr[0])
			begin
				ref_mem[bank][idx][31:16] = model_q[sect].pop_front();
				ref_en[bank][idx] = ref_en[bank][idx] | 4'b1100;
			end
			else
			begin
				ref_mem[bank][idx][15:0] = model_q[sect].pop_front();
				ref_en[bank][idx] = ref_en[bank][idx] | 4'b0011;
			end
			if (touched.size() == 0 || touched[touched.size()-1] != (addr >> 1))
			begin
				touched.push_back(addr >> 1);
			end
		end
		@(negedge CLK);
		pop_base = pop_total;
		write_base = write_total;
		issue = 1'b1;
		section = section_t'(sect);
		start_address = word_addr_t'(start);
		count_req = count_t'(cnt);
		dram_sel = (bank == 0) ? 2'b01 : 2'b10;
		@(negedge CLK);
		issue = 1'b0;
		while (done !== 1'b1)
		begin
			@(negedge CLK);
		end
		check_value("count_sent", 32'(n_sent), 32'(count_sent));
		check_value("abrupt_stop", 32'(n_sent < cnt), 32'(abrupt_stop));
		check_value("irq_out", 32'(model_q[sect].size() == 16), 32'(irq_out));
		// Busy shows one cycle late, so working is still high while done pulses
		check_value("working", 1, 32'(working));
		// Let the last bank write land
		repeat (2) @(negedge CLK);
		check_value("working", 0, 32'(working));
		check_value("lsab_read pulses", 32'(n_sent), 32'(pop_total - pop_base));
		check_value("request_access pulses", 32'(touched.size()), 32'(write_total - write_base));
		foreach (touched[k])
		begin
			rd_bank = (bank != 0);
			rd_addr = dram_addr_t'(touched[k]);
			@(negedge CLK);
			idx = touched[k] % 64;
			mask = '0;
			for (i = 0; i < 4; i++)
			begin
				if (ref_en[bank][idx][i])
				begin
					mask[i*8 +: 8] = 8'hFF;
				end
			end
			check_value($sformatf("rd_data bank %0d word %0d", bank, idx),
				ref_mem[bank][idx] & mask, rd_data & mask);
		end
	endtask

	//####################################################################
	// Test sequence
	//####################################################################
	initial
	begin
		seed = 29120;
		RST = 1'b0;
		fill_write = 1'b0;
		fill_section = '0;
		fill_data = '0;
		issue = 1'b0;
		start_address = '0;
		count_req = '0;
		section = '0;
		dram_sel = '0;
		rd_bank = 1'b0;
		rd_addr = '0;
		foreach (ref_en[b, w])
		begin
			ref_en[b][w] = 4'b0000;
			ref_mem[b][w] = '0;
		end
		repeat (16) @(negedge CLK);
		RST = 1'b1;
		@(negedge CLK);
		check_value("working", 0, 32'(working));
		check_value("done", 0, 32'(done));
		check_value("irq_out", 0, 32'(irq_out));
		check_value("abrupt_stop", 0, 32'(abrupt_stop));
		check_value("lsab_read", 0, 32'(lsab_read));
		check_value("request_access", 0, 32'(request_access));
		check_value("count_sent", 0, 32'(count_sent));

		// Without an issue nothing leaves the sections
		fill(0, 10);
		repeat (20) @(negedge CLK);
		check_value("idle lsab_read pulses", 0, pop_total);
		check_value("idle request_access pulses", 0, write_total);

		do_move(0, 'h020, 10, 0);
		// Section runs dry after 5 of 9 words
		fill(1, 5);
		do_move(1, 'h040, 9, 0);
		// Background words, then a lone odd half at the start of an odd move
		fill(2, 8);
		do_move(2, 'h060, 8, 1);
		fill(2, 5);
		do_move(2, 'h061, 5, 1);
		// A full section is flagged, a partly filled one is not
		fill(3, 16);
		do_move(3, 'h100, 0, 0);
		do_move(3, 'h100, 3, 0);
		// Section 1 is empty at the start
		do_move(1, 'h080, 4, 1);

		repeat (4) @(negedge CLK);
		if (hyper_mover_top_inst.mvblck_ctrl_inst.mover_properties_inst.fail_count == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			$display("Simulation FAILED");
			$fatal(1, "property failure at the end of the run");
		end
	end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/hyper_types_pkg.sv
rtl/hyper_state_pkg.sv
rtl/lsab_if.sv
rtl/lsab_sections.sv
rtl/mvblck_ctrl.sv
rtl/mcu_collector.sv
rtl/dram_banks.sv
rtl/hyper_mover_top.sv
tests/mover_properties.sv
tests/mover_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the block mover testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module mover_tb -o mover_sim

# The simulator exits non-zero on a failure; the log decides the result
./obj_dir/mover_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "Run reported a failure"
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "Run ended without a result"
	exit 1
fi
exit 0
